/* Makefile */
TOP = ooo_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): ooo_commit.f hw/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f ooo_commit.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* hw/circular_queue.sv */
module circular_queue #(
    parameter type QUEUE_TYPE = logic,
    parameter int DEPTH = 8,
    parameter int SS = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear,
    input  logic                     push,
    input  QUEUE_TYPE                push_data [SS],
    input  logic                     pop,
    input  logic                     wr_en [SS],
    input  logic [$clog2(DEPTH)-1:0] wr_sel [SS],
    input  QUEUE_TYPE                wr_data [SS],
    output QUEUE_TYPE                head_data [SS],
    output logic [$clog2(DEPTH)-1:0] tail_ptr,
    output logic                     space_ok,
    output logic                     empty
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    QUEUE_TYPE mem [DEPTH];

    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [CNT_W-1:0] count_q;

    // pointer advance with wrap at DEPTH, which need not be a power of two
    function automatic logic [IDX_W-1:0] ring_add(input logic [IDX_W-1:0] base,
                                                  input int offset);
        int sum;
        sum = int'(base) + offset;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return IDX_W'(sum);
    endfunction

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (push) begin
                tail_q <= ring_add(tail_q, SS);
            end
            if (pop) begin
                head_q <= ring_add(head_q, SS);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + CNT_W'(SS);
                2'b01:   count_q <= count_q - CNT_W'(SS);
                default: count_q <= count_q;
            endcase
        end
    end

    // group writes land first, then indexed updates of occupied slots
    always_ff @(posedge clk) begin
        for (int i = 0; i < SS; i++) begin
            if (push) begin
                mem[ring_add(tail_q, i)] <= push_data[i];
            end
        end
        for (int i = 0; i < SS; i++) begin
            if (wr_en[i]) begin
                mem[wr_sel[i]] <= wr_data[i];
            end
        end
    end

    // window onto the SS oldest entries
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            head_data[i] = mem[ring_add(head_q, i)];
        end
    end

    assign tail_ptr = tail_q;
    assign empty    = (count_q == '0);
    assign space_ok = (int'(count_q) + SS) <= DEPTH;

endmodule

/* hw/dispatch_stage.sv */
module dispatch_stage
    import ooo_pkg::*;
#(
    parameter int SS = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         inst_valid,
    input  inst_t                        inst_group [SS],
    input  logic                         space_ok,
    input  logic                         flush_now,
    input  logic [$clog2(ROB_DEPTH)-1:0] tail_id,
    input  logic                         lane_busy [SS],
    output logic                         dispatch_ready,
    output logic                         push,
    output rob_entry_t                   push_entries [SS],
    output logic                         lane_start,
    output inst_t                        lane_inst [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] lane_rob_id [SS]
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic lanes_idle;

    always_comb begin
        lanes_idle = 1'b1;
        for (int i = 0; i < SS; i++) begin
            if (lane_busy[i]) begin
                lanes_idle = 1'b0;
            end
        end
    end

    // a retiring flush owns this cycle
    assign dispatch_ready = space_ok && lanes_idle && !flush_now;
    assign push           = inst_valid && dispatch_ready;

    // new entries enter the buffer with nothing written back yet
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            push_entries[i].inst       = inst_group[i];
            push_entries[i].done       = 1'b0;
            push_entries[i].result     = '0;
            push_entries[i].mispredict = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_start <= 1'b0;
        end else begin
            lane_start <= push;
        end
    end

    // groups stay aligned to SS, so tail_id + i never wraps
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < SS; i++) begin
                lane_inst[i]   <= inst_group[i];
                lane_rob_id[i] <= tail_id + IDX_W'(i);
            end
        end
    end

endmodule

/* hw/fu_lane.sv */
module fu_lane
    import ooo_pkg::*;
#(
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush_now,
    input  logic                         start,
    input  inst_t                        inst,
    input  logic [$clog2(ROB_DEPTH)-1:0] rob_id,
    output logic                         busy,
    output cdb_t                         cdb
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic              pending_q;
    logic [1:0]        count_q;
    logic [DATA_W-1:0] result_q;
    logic [IDX_W-1:0]  rob_id_q;

    logic              is_mul;
    logic              taken;
    logic [DATA_W-1:0] fast_result;
    logic              fast_mispredict;

    always_comb begin
        is_mul = (inst.op == OP_MUL);
        taken  = (inst.a == inst.b);
        case (inst.op)
            OP_ADD:  fast_result = inst.a + inst.b;
            OP_SUB:  fast_result = inst.a - inst.b;
            OP_BEQ:  fast_result = DATA_W'(taken);
            default: fast_result = '0;
        endcase
        fast_mispredict = (inst.op == OP_BEQ) && (taken != inst.predict_taken);
    end

    // mul waits out its countdown before the strobe
    always_ff @(posedge clk) begin
        if (rst || flush_now) begin
            pending_q <= 1'b0;
        end else if (start && is_mul) begin
            pending_q <= 1'b1;
        end else if (pending_q && count_q == 2'd0) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            count_q  <= inst.b[1:0];
            result_q <= inst.a * inst.b;
            rob_id_q <= rob_id;
        end else if (pending_q && count_q != 2'd0) begin
            count_q <= count_q - 2'd1;
        end
    end

    // single-cycle ops strobe in the start cycle itself
    always_comb begin
        cdb.valid      = 1'b0;
        cdb.rob_id     = ROB_ID_W'(rob_id_q);
        cdb.result     = result_q;
        cdb.mispredict = 1'b0;
        if (start && !is_mul) begin
            cdb.valid      = !flush_now;
            cdb.rob_id     = ROB_ID_W'(rob_id);
            cdb.result     = fast_result;
            cdb.mispredict = fast_mispredict;
        end else if (pending_q && count_q == 2'd0) begin
            cdb.valid = !flush_now;
        end
    end

    assign busy = start || pending_q;

endmodule

/* hw/ooo_core_top.sv */
module ooo_core_top
    import ooo_pkg::*;
#(
    parameter int SS = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inst_valid,
    input  inst_t   inst_group [SS],
    output logic    dispatch_ready,
    output commit_t commit [SS],
    output logic    flush
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic             push;
    rob_entry_t       push_entries [SS];
    logic [IDX_W-1:0] tail_id;
    logic             space_ok;
    logic             flush_now;
    logic             lane_start;
    inst_t            lane_inst [SS];
    logic [IDX_W-1:0] lane_rob_id [SS];
    logic             lane_busy [SS];
    cdb_t             cdb [SS];

    dispatch_stage #(
        .SS        (SS),
        .ROB_DEPTH (ROB_DEPTH)
    ) dispatch_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_group     (inst_group),
        .space_ok       (space_ok),
        .flush_now      (flush_now),
        .tail_id        (tail_id),
        .lane_busy      (lane_busy),
        .dispatch_ready (dispatch_ready),
        .push           (push),
        .push_entries   (push_entries),
        .lane_start     (lane_start),
        .lane_inst      (lane_inst),
        .lane_rob_id    (lane_rob_id)
    );

    // one lane per group slot, all started together
    for (genvar i = 0; i < SS; i++) begin : g_lane
        fu_lane #(
            .ROB_DEPTH (ROB_DEPTH)
        ) fu_lane_inst (
            .clk       (clk),
            .rst       (rst),
            .flush_now (flush_now),
            .start     (lane_start),
            .inst      (lane_inst[i]),
            .rob_id    (lane_rob_id[i]),
            .busy      (lane_busy[i]),
            .cdb       (cdb[i])
        );
    end

    rob #(
        .SS        (SS),
        .ROB_DEPTH (ROB_DEPTH)
    ) rob_inst (
        .clk          (clk),
        .rst          (rst),
        .push         (push),
        .push_entries (push_entries),
        .cdb          (cdb),
        .tail_id      (tail_id),
        .space_ok     (space_ok),
        .flush_now    (flush_now),
        .commit       (commit),
        .flush        (flush)
    );

endmodule

/* hw/ooo_pkg.sv */
package ooo_pkg;

    // operand and result width
    localparam int DATA_W = 32;

    // testbench tag carried with each instruction to identify it at retirement
    localparam int TAG_W = 8;

    // width of the running retirement order counter
    localparam int ORDER_W = 32;

    // bus ids are sized for the deepest reorder buffer allowed
    localparam int MAX_ROB_DEPTH = 16;
    localparam int ROB_ID_W = $clog2(MAX_ROB_DEPTH);

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_BEQ = 2'd3
    } op_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        op_t               op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic              predict_taken;
    } inst_t;

    typedef struct packed {
        inst_t             inst;
        logic              done;
        logic [DATA_W-1:0] result;
        logic              mispredict;
    } rob_entry_t;

    typedef struct packed {
        logic                valid;
        logic [ROB_ID_W-1:0] rob_id;
        logic [DATA_W-1:0]   result;
        logic                mispredict;
    } cdb_t;

    typedef struct packed {
        logic               valid;
        logic [TAG_W-1:0]   tag;
        logic [DATA_W-1:0]  result;
        logic               mispredict;
        logic [ORDER_W-1:0] order;
    } commit_t;

endpackage

/* hw/rob.sv */
module rob
    import ooo_pkg::*;
#(
    parameter int SS = 2,
    parameter int ROB_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  rob_entry_t                   push_entries [SS],
    input  cdb_t                         cdb [SS],
    output logic [$clog2(ROB_DEPTH)-1:0] tail_id,
    output logic                         space_ok,
    output logic                         flush_now,
    output commit_t                      commit [SS],
    output logic                         flush
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    rob_entry_t         head_data [SS];
    logic               wr_en [SS];
    logic [IDX_W-1:0]   wr_sel [SS];
    rob_entry_t         wr_data [SS];
    logic               empty;
    logic               pop;
    logic               slot_valid [SS];
    logic [ORDER_W-1:0] retire_count;
    logic [ORDER_W-1:0] order_q;

    circular_queue #(
        .QUEUE_TYPE (rob_entry_t),
        .DEPTH      (ROB_DEPTH),
        .SS         (SS)
    ) rob_queue (
        .clk        (clk),
        .rst        (rst),
        .clear      (flush_now),
        .push       (push),
        .push_data  (push_entries),
        .pop        (pop),
        .wr_en      (wr_en),
        .wr_sel     (wr_sel),
        .wr_data    (wr_data),
        .head_data  (head_data),
        .tail_ptr   (tail_id),
        .space_ok   (space_ok),
        .empty      (empty)
    );

    // only the head group has lanes in flight, and lane i always
    // serves slot i of a group, so head slot i supplies the instruction
    always_comb begin
        for (int i = 0; i < SS; i++) begin
            wr_en[i]              = cdb[i].valid;
            wr_sel[i]             = cdb[i].rob_id[IDX_W-1:0];
            wr_data[i]            = head_data[i];
            wr_data[i].done       = 1'b1;
            wr_data[i].result     = cdb[i].result;
            wr_data[i].mispredict = cdb[i].mispredict;
        end
    end

    // retire the head group once every slot has written back
    always_comb begin
        logic seen_mispredict;
        pop = !empty;
        for (int i = 0; i < SS; i++) begin
            if (!head_data[i].done) begin
                pop = 1'b0;
            end
        end
        seen_mispredict = 1'b0;
        retire_count    = '0;
        flush_now       = 1'b0;
        for (int i = 0; i < SS; i++) begin
            // slots younger than a mispredict are squashed
            slot_valid[i] = pop && !seen_mispredict;
            if (slot_valid[i]) begin
                retire_count = retire_count + 1'b1;
            end
            if (slot_valid[i] && head_data[i].mispredict) begin
                flush_now = 1'b1;
            end
            seen_mispredict = seen_mispredict || head_data[i].mispredict;
        end
    end

    always_ff @(posedge clk) begin
        // valid slots are contiguous from slot 0, so slot i takes order + i
        for (int i = 0; i < SS; i++) begin
            commit[i].tag        <= head_data[i].inst.tag;
            commit[i].result     <= head_data[i].result;
            commit[i].mispredict <= head_data[i].mispredict;
            commit[i].order      <= order_q + ORDER_W'(i);
        end
        if (rst) begin
            order_q <= '0;
            flush   <= 1'b0;
            for (int i = 0; i < SS; i++) begin
                commit[i].valid <= 1'b0;
            end
        end else begin
            order_q <= order_q + retire_count;
            flush   <= flush_now;
            for (int i = 0; i < SS; i++) begin
                commit[i].valid <= slot_valid[i];
            end
        end
    end

endmodule

/* ooo_commit.f */
+incdir+verif
hw/ooo_pkg.sv
hw/circular_queue.sv
hw/dispatch_stage.sv
hw/fu_lane.sv
hw/rob.sv
hw/ooo_core_top.sv
verif/ooo_assertions.sv
verif/ooo_tb.sv

/* verif/ooo_assertions.sv */
module ooo_assertions
    import ooo_pkg::*;
#(
    parameter int SS = 2
) (
    input logic    clk,
    input logic    rst,
    input commit_t commit [SS],
    input logic    flush
);

    timeunit 1ns;
    timeprecision 1ps;

    logic any_valid;
    logic mispredict_retired;

    always_comb begin
        any_valid          = 1'b0;
        mispredict_retired = 1'b0;
        for (int i = 0; i < SS; i++) begin
            if (commit[i].valid) begin
                any_valid = 1'b1;
            end
            if (commit[i].valid && commit[i].mispredict) begin
                mispredict_retired = 1'b1;
            end
        end
    end

    // valid slots form a prefix of the group
    for (genvar i = 1; i < SS; i++) begin : g_prefix
        commit_prefix: assert property (@(posedge clk) disable iff (rst)
            commit[i].valid |-> commit[i - 1].valid)
            else $error("commit slot %0d valid while an older slot is not", i);
    end

    flush_cause: assert property (@(posedge clk) disable iff (rst)
        flush |-> mispredict_retired)
        else $error("flush without a retiring mispredict");

    // the queue was cleared, so the following cycle retires nothing
    quiet_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> !any_valid)
        else $error("commit valid in the cycle after a flush");

endmodule

bind rob ooo_assertions #(
    .SS (SS)
) rob_checks (
    .clk    (clk),
    .rst    (rst),
    .commit (commit),
    .flush  (flush)
);

/* verif/ooo_model.svh */
`ifndef OOO_MODEL_SVH
`define OOO_MODEL_SVH

// accepted instructions in program order, not yet retired or flushed
inst_t pending_q [$];

// order value the next retirement must carry
logic [ORDER_W-1:0] next_order = '0;

int unsigned accepted_count        = 0;
int unsigned squashed_count        = 0;
int unsigned expected_squash_count = 0;
int unsigned flush_count           = 0;

// architectural result of one instruction
function automatic logic [DATA_W-1:0] expected_result(input inst_t inst);
    logic [2*DATA_W-1:0] product;
    product = {{DATA_W{1'b0}}, inst.a} * {{DATA_W{1'b0}}, inst.b};
    case (inst.op)
        OP_ADD:  return inst.a + inst.b;
        OP_SUB:  return inst.a - inst.b;
        OP_MUL:  return product[DATA_W-1:0];
        default: return (inst.a == inst.b) ? DATA_W'(1) : DATA_W'(0);
    endcase
endfunction

// only a branch whose outcome differs from its prediction mispredicts
function automatic logic expected_mispredict(input inst_t inst);
    if (inst.op != OP_BEQ) begin
        return 1'b0;
    end
    return (inst.a == inst.b) ^ inst.predict_taken;
endfunction

// cycles from acceptance to the bus strobe
function automatic int lane_latency(input inst_t inst);
    if (inst.op == OP_MUL) begin
        return 2 + int'(inst.b[1:0]);
    end
    return 1;
endfunction

task automatic record_group(input inst_t grp [SS]);
    logic behind_mispredict;
    behind_mispredict = 1'b0;
    for (int i = 0; i < SS; i++) begin
        pending_q.push_back(grp[i]);
        // slots behind the group's first mispredict never retire
        if (behind_mispredict) begin
            expected_squash_count++;
        end
        if (expected_mispredict(grp[i])) begin
            behind_mispredict = 1'b1;
        end
    end
    accepted_count += SS;
endtask

// everything left behind a retiring mispredict is younger and squashed
task automatic discard_pending();
    squashed_count += pending_q.size();
    pending_q.delete();
endtask

`endif

/* verif/ooo_tb.sv */
module ooo_tb
    import ooo_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SS               = 2;
    localparam int ROB_DEPTH        = 8;
    localparam int NUM_GROUPS       = 300;
    localparam int RESET_CYCLES     = 10;
    localparam int CYCLES_PER_GROUP = 12;
    localparam int CYCLE_LIMIT      = NUM_GROUPS * CYCLES_PER_GROUP + RESET_CYCLES;
    localparam int DRAIN_CYCLES     = 8;

    logic    clk = 1'b0;
    logic    rst;
    logic    inst_valid;
    inst_t   inst_group [SS];
    logic    dispatch_ready;
    commit_t commit [SS];
    logic    flush;

    int unsigned cycle_count    = 0;
    int unsigned overtake_count = 0;

    `include "ooo_model.svh"

    ooo_core_top #(
        .SS        (SS),
        .ROB_DEPTH (ROB_DEPTH)
    ) ooo_core_top_inst (
        .clk            (clk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_group     (inst_group),
        .dispatch_ready (dispatch_ready),
        .commit         (commit),
        .flush          (flush)
    );

    always #20 clk = ~clk;

    task automatic fail_check(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    function automatic string mismatch_text(input string test, input logic [63:0] expected,
                                            input logic [63:0] actual);
        return $sformatf("mismatch in %s: expected %0h, actual %0h", test, expected, actual);
    endfunction

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            fail_check($sformatf("timeout: run did not finish within %0d cycles", CYCLE_LIMIT));
        end
    end

    // 40% add/sub, 30% mul, 30% beq
    function automatic inst_t random_inst(input logic [TAG_W-1:0] tag);
        inst_t       inst;
        int unsigned pick;
        pick               = $urandom_range(99);
        inst.tag           = tag;
        inst.a             = $urandom();
        inst.b             = $urandom();
        inst.predict_taken = ($urandom_range(1) == 1);
        if (pick < 20) begin
            inst.op = OP_ADD;
        end else if (pick < 40) begin
            inst.op = OP_SUB;
        end else if (pick < 70) begin
            inst.op = OP_MUL;
        end else begin
            inst.op = OP_BEQ;
        end
        // equal operands half the time so both branch outcomes occur
        if (inst.op == OP_BEQ && $urandom_range(1) == 1) begin
            inst.b = inst.a;
        end
        return inst;
    endfunction

    // outputs are registered at the rising edge, so they are stable here
    task automatic check_outputs();
        inst_t oldest;
        logic  any_busy;
        logic  saw_mispredict;
        string slot;
        any_busy = 1'b0;
        for (int i = 0; i < SS; i++) begin
            if (ooo_core_top_inst.lane_busy[i]) begin
                any_busy = 1'b1;
            end
        end
        assert (!(any_busy && dispatch_ready))
            else fail_check("dispatch_ready is high while a lane is busy");
        if (accepted_count == 0) begin
            assert (!flush) else fail_check("flush pulsed before any group was accepted");
        end
        saw_mispredict = 1'b0;
        for (int i = 0; i < SS; i++) begin
            if (commit[i].valid) begin
                slot = $sformatf("slot %0d", i);
                assert (!saw_mispredict)
                    else fail_check("an instruction younger than a mispredict retired");
                assert (pending_q.size() > 0)
                    else fail_check("commit is valid with no outstanding instruction");
                oldest = pending_q.pop_front();
                assert (commit[i].tag == oldest.tag)
                    else fail_check(mismatch_text({"tag ", slot}, 64'(oldest.tag),
                                                  64'(commit[i].tag)));
                assert (commit[i].result == expected_result(oldest))
                    else fail_check(mismatch_text({"result ", slot},
                                                  64'(expected_result(oldest)),
                                                  64'(commit[i].result)));
                assert (commit[i].mispredict == expected_mispredict(oldest))
                    else fail_check(mismatch_text({"mispredict ", slot},
                                                  64'(expected_mispredict(oldest)),
                                                  64'(commit[i].mispredict)));
                assert (commit[i].order == next_order)
                    else fail_check(mismatch_text({"order ", slot}, 64'(next_order),
                                                  64'(commit[i].order)));
                next_order++;
                saw_mispredict = commit[i].mispredict;
            end
        end
        assert (flush == saw_mispredict)
            else fail_check("flush does not match a retiring mispredict");
        if (flush) begin
            flush_count++;
            discard_pending();
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        int               gap;
        logic [TAG_W-1:0] next_tag;
        void'($urandom(32'h195));
        rst        = 1'b1;
        inst_valid = 1'b0;
        next_tag   = '0;
        for (int i = 0; i < SS; i++) begin
            inst_group[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_outputs();
        assert (dispatch_ready) else fail_check("dispatch_ready is low after reset");

        for (int g = 0; g < NUM_GROUPS; g++) begin
            for (int i = 0; i < SS; i++) begin
                inst_group[i] = random_inst(next_tag);
                next_tag++;
            end
            // a later slot with a shorter latency finishes first
            for (int i = 0; i < SS - 1; i++) begin
                if (lane_latency(inst_group[i]) > lane_latency(inst_group[i + 1])) begin
                    overtake_count++;
                end
            end
            inst_valid = 1'b1;
            while (!dispatch_ready) begin
                next_cycle();
            end
            record_group(inst_group);
            next_cycle();
            inst_valid = 1'b0;
            gap = $urandom_range(3);
            repeat (gap) next_cycle();
        end

        while (pending_q.size() != 0) begin
            next_cycle();
        end
        // nothing may retire once the model is empty
        repeat (DRAIN_CYCLES) next_cycle();

        // a flush drops only the slots behind the mispredict in its own group
        assert (squashed_count == expected_squash_count)
            else fail_check(mismatch_text("squashed count", 64'(expected_squash_count),
                                          64'(squashed_count)));
        assert (flush_count > 0) else fail_check("no mispredict flush was exercised");
        assert (overtake_count > 0)
            else fail_check("no group let a later instruction finish first");
        $display("Verification passed");
        $finish;
    end

endmodule
